//--- hw/lcd_pkg.sv
package lcd_pkg;

    // **************************************************
    // clock and the long delays of the HD44780 init
    // **************************************************

    // the design runs from one fixed system clock, every tick count below follows from it
    localparam int CLK_FREQ_HZ = 10_000_000;

    // a nibble on the 4-bit data bus, the display only looks at DB7..DB4
    typedef logic [3:0] nibble_t;

    // a full command or character as the host hands it over
    typedef logic [7:0] lcd_byte_t;

    // the delay counter has to hold 100 ms worth of clocks at 10 MHz
    typedef logic [19:0] delay_ticks_t;

    // power on wait before the first nibble, 100 ms
    localparam delay_ticks_t DELAY_POWER_ON = delay_ticks_t'(CLK_FREQ_HZ / 10);
    // the first 0x3 nibble takes much longer than the ones that follow, 4.1 ms
    localparam delay_ticks_t DELAY_FNSET1   = delay_ticks_t'((CLK_FREQ_HZ / 10_000) * 41);
    // the later reset nibbles and the 4-bit switch get 100 us each
    localparam delay_ticks_t DELAY_100US    = delay_ticks_t'(CLK_FREQ_HZ / 10_000);
    // execution time of an ordinary command or a character write, 53 us
    localparam delay_ticks_t DELAY_CMD      = delay_ticks_t'((CLK_FREQ_HZ / 1_000_000) * 53);
    // clear display and return home touch all of DDRAM, 3 ms
    localparam delay_ticks_t DELAY_CLEAR    = delay_ticks_t'((CLK_FREQ_HZ / 1_000) * 3);

    // the two commands that need the long execution time
    localparam lcd_byte_t LCD_CMD_CLEAR = 8'h01;
    localparam lcd_byte_t LCD_CMD_HOME  = 8'h02;

    // **************************************************
    // E pulse timing of one nibble write
    // **************************************************

    // address setup before E rises, 60 ns min
    localparam int TICKS_TAS    = 1;
    // E high width, 450 ns min
    localparam int TICKS_PWEH   = 5;
    // the whole enable cycle, 1 us min
    localparam int TICKS_TCYCE  = 10;
    // wide enough to hold TICKS_TCYCE
    localparam int NIBBLE_CNT_W = 4;

    // what the nibble writer puts on the display pins
    typedef struct packed {
        logic    rs;
        logic    e;
        nibble_t data;
    } lcd_bus_t;

    // one nibble request from the sequencer to the writer
    typedef struct packed {
        logic    rs;
        nibble_t data;
    } nibble_req_t;

    // **************************************************
    // power on init table
    // **************************************************

    // a step is either a lone nibble (the 8-bit style reset nibbles) or a full byte sent as two
    typedef struct packed {
        nibble_t      nibble;
        logic         is_byte;
        lcd_byte_t    value;
        delay_ticks_t delay;
    } init_step_t;

    localparam int INIT_STEPS = 9;
    localparam int STEP_IDX_W = $clog2(INIT_STEPS + 1);

    // the index has to reach INIT_STEPS so the sequencer can tell that the table is done
    typedef logic [STEP_IDX_W-1:0] step_idx_t;

    localparam init_step_t INIT_TABLE [INIT_STEPS] = '{
        '{nibble: 4'h3, is_byte: 1'b0, value: 8'h00, delay: DELAY_FNSET1},
        '{nibble: 4'h3, is_byte: 1'b0, value: 8'h00, delay: DELAY_100US},
        '{nibble: 4'h3, is_byte: 1'b0, value: 8'h00, delay: DELAY_100US},
        '{nibble: 4'h2, is_byte: 1'b0, value: 8'h00, delay: DELAY_100US},
        '{nibble: 4'h0, is_byte: 1'b1, value: 8'h28, delay: DELAY_CMD},
        '{nibble: 4'h0, is_byte: 1'b1, value: 8'h08, delay: DELAY_CMD},
        '{nibble: 4'h0, is_byte: 1'b1, value: 8'h01, delay: DELAY_CLEAR},
        '{nibble: 4'h0, is_byte: 1'b1, value: 8'h06, delay: DELAY_CMD},
        '{nibble: 4'h0, is_byte: 1'b1, value: 8'h0C, delay: DELAY_CMD}
    };

    // sequencer states, the init ones walk the table and the byte ones serve the host
    typedef enum logic [2:0] {
        ST_INIT_LOAD,
        ST_INIT_HI,
        ST_INIT_LO,
        ST_INIT_WAIT,
        ST_IDLE,
        ST_BYTE_HI,
        ST_BYTE_LO,
        ST_BYTE_WAIT
    } seq_state_t;

endpackage

//--- hw/lcd_delay_timer.sv
`timescale 1ns/10ps

module lcd_delay_timer (
    input  logic                  CLK_I,
    input  logic                  RST_I,
    input  logic                  i_load,
    input  lcd_pkg::delay_ticks_t i_ticks,
    output logic                  o_expired
);
    import lcd_pkg::*;

    // remaining cycles, holds N in the cycle right after the load
    delay_ticks_t cnt_q;
    // set while a delay is running, so an idle counter never reports expiry
    logic         active_q;

    // **************************************************
    // down-counter
    // **************************************************

    // a load restarts the count even when a delay is already running
    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            cnt_q    <= '0;
            active_q <= 1'b0;
        end else if (i_load) begin
            cnt_q    <= i_ticks;
            active_q <= 1'b1;
        end else if (active_q) begin
            if (o_expired) begin
                // the pulse cycle ends the delay
                active_q <= 1'b0;
            end else begin
                cnt_q <= cnt_q - delay_ticks_t'(1);
            end
        end
    end

    // the count holds N one cycle after the load and reaches 1 in cycle N,
    // so expiry at one lands exactly N cycles after the load cycle
    // a load of zero is already below two in the next cycle and gives its single pulse there
    assign o_expired = active_q && (cnt_q < delay_ticks_t'(2));

endmodule

//--- hw/lcd_nibble_writer.sv
`timescale 1ns/10ps

module lcd_nibble_writer (
    input  logic                 CLK_I,
    input  logic                 RST_I,
    input  logic                 i_start,
    input  lcd_pkg::nibble_req_t i_req,
    output logic                 o_done,
    output lcd_pkg::lcd_bus_t    o_bus
);
    import lcd_pkg::*;

    // cycle counter, TICKS_TCYCE in the first cycle after start and 1 in the last one
    logic [NIBBLE_CNT_W-1:0] cnt_q;
    // a nibble cycle is in flight
    logic                    active_q;
    // the E pin, registered so the display never sees a decode glitch
    logic                    e_q;
    // nibble and RS as they were at start
    nibble_req_t             req_q;

    // **************************************************
    // enable cycle sequencing
    // **************************************************

    // the counter runs TICKS_TCYCE down to 1
    // cycle k after start holds TICKS_TCYCE - k + 1, which places every E edge below
    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            cnt_q    <= '0;
            active_q <= 1'b0;
            e_q      <= 1'b0;
        end else if (i_start) begin
            cnt_q    <= NIBBLE_CNT_W'(TICKS_TCYCE);
            active_q <= 1'b1;
            // a new nibble always starts with E low for the setup time
            e_q      <= 1'b0;
        end else if (active_q) begin
            // data has been on the bus for TICKS_TAS cycles after this edge
            if (cnt_q == NIBBLE_CNT_W'(TICKS_TCYCE - TICKS_TAS + 1)) begin
                e_q <= 1'b1;
            end
            // the display latches the nibble on this falling edge
            if (cnt_q == NIBBLE_CNT_W'(TICKS_TCYCE - TICKS_TAS - TICKS_PWEH + 1)) begin
                e_q <= 1'b0;
            end
            if (o_done) begin
                active_q <= 1'b0;
            end else begin
                cnt_q <= cnt_q - NIBBLE_CNT_W'(1);
            end
        end
    end

    // **************************************************
    // bus payload
    // **************************************************

    // data and RS change only at a start, which keeps them steady through
    // the whole E pulse and the hold time whatever the sequencer does meanwhile
    always_ff @(posedge CLK_I) begin
        if (i_start) begin
            req_q <= i_req;
        end
    end

    // the last cycle of the enable cycle time, the next nibble may start right after
    assign o_done = active_q && (cnt_q == NIBBLE_CNT_W'(1));

    assign o_bus.rs   = req_q.rs;
    assign o_bus.e    = e_q;
    assign o_bus.data = req_q.data;

endmodule

//--- hw/lcd_step_sequencer.sv
`timescale 1ns/10ps

module lcd_step_sequencer (
    input  logic                  CLK_I,
    input  logic                  RST_I,
    input  logic                  i_stb,
    input  logic                  i_rs,
    input  lcd_pkg::lcd_byte_t    i_data,
    output logic                  o_busy,
    output logic                  o_nib_start,
    output lcd_pkg::nibble_req_t  o_nib_req,
    input  logic                  i_nib_done,
    output logic                  o_dly_load,
    output lcd_pkg::delay_ticks_t o_dly_ticks,
    input  logic                  i_dly_expired
);
    import lcd_pkg::*;

    seq_state_t   state_q;
    seq_state_t   state_d;
    // next table entry to send, reaches INIT_STEPS after the last one
    step_idx_t    step_idx_q;
    // a nibble was started and its done pulse has not come back yet
    logic         nib_wait_q;
    // the host byte being sent
    logic         byte_rs_q;
    lcd_byte_t    byte_data_q;
    init_step_t   cur_step;
    delay_ticks_t byte_delay;
    logic         nib_done;
    logic         accept;
    logic         step_done;

    // the index only points past the table while waiting out the last delay
    assign cur_step = (step_idx_q < STEP_IDX_W'(INIT_STEPS)) ? INIT_TABLE[step_idx_q] : '0;

    // clear and return home need the long execution time, every other byte gets the short one
    // data writes never do, whatever their code
    assign byte_delay = (!byte_rs_q && (byte_data_q == LCD_CMD_CLEAR ||
                                        byte_data_q == LCD_CMD_HOME)) ? DELAY_CLEAR : DELAY_CMD;

    // a done pulse only counts for a nibble this block actually launched
    assign nib_done = nib_wait_q && i_nib_done;

    // busy covers init and the whole byte including its execution time
    assign o_busy = (state_q != ST_IDLE);

    // **************************************************
    // next state and handshake outputs
    // **************************************************

    always_comb begin
        state_d       = state_q;
        o_nib_start   = 1'b0;
        o_nib_req.rs  = 1'b0;
        o_nib_req.data = '0;
        o_dly_load    = 1'b0;
        o_dly_ticks   = DELAY_POWER_ON;
        accept        = 1'b0;
        step_done     = 1'b0;

        case (state_q)
            // first thing out of reset, the display needs its power on wait
            ST_INIT_LOAD: begin
                o_dly_load = 1'b1;
                state_d    = ST_INIT_WAIT;
            end

            // one start pulse per state, then wait for the writer
            // the reset nibbles go out alone and full bytes go upper nibble first
            ST_INIT_HI: begin
                o_nib_start    = !nib_wait_q;
                o_nib_req.data = cur_step.is_byte ? cur_step.value[7:4] : cur_step.nibble;
                o_dly_ticks    = cur_step.delay;
                if (nib_done) begin
                    if (cur_step.is_byte) begin
                        state_d = ST_INIT_LO;
                    end else begin
                        o_dly_load = 1'b1;
                        step_done  = 1'b1;
                        state_d    = ST_INIT_WAIT;
                    end
                end
            end

            ST_INIT_LO: begin
                o_nib_start    = !nib_wait_q;
                o_nib_req.data = cur_step.value[3:0];
                o_dly_ticks    = cur_step.delay;
                if (nib_done) begin
                    o_dly_load = 1'b1;
                    step_done  = 1'b1;
                    state_d    = ST_INIT_WAIT;
                end
            end

            // shared by the power on wait and every step delay
            // the index tells whether the table still has entries left
            ST_INIT_WAIT: begin
                if (i_dly_expired) begin
                    state_d = (step_idx_q == STEP_IDX_W'(INIT_STEPS)) ? ST_IDLE : ST_INIT_HI;
                end
            end

            // strobes are only looked at here, a strobe in any other state is dropped
            ST_IDLE: begin
                if (i_stb) begin
                    accept  = 1'b1;
                    state_d = ST_BYTE_HI;
                end
            end

            ST_BYTE_HI: begin
                o_nib_start    = !nib_wait_q;
                o_nib_req.rs   = byte_rs_q;
                o_nib_req.data = byte_data_q[7:4];
                if (nib_done) begin
                    state_d = ST_BYTE_LO;
                end
            end

            ST_BYTE_LO: begin
                o_nib_start    = !nib_wait_q;
                o_nib_req.rs   = byte_rs_q;
                o_nib_req.data = byte_data_q[3:0];
                o_dly_ticks    = byte_delay;
                if (nib_done) begin
                    o_dly_load = 1'b1;
                    state_d    = ST_BYTE_WAIT;
                end
            end

            ST_BYTE_WAIT: begin
                if (i_dly_expired) begin
                    state_d = ST_IDLE;
                end
            end

            default: begin
                state_d = ST_INIT_LOAD;
            end
        endcase
    end

    // **************************************************
    // state registers
    // **************************************************

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            state_q    <= ST_INIT_LOAD;
            step_idx_q <= '0;
            nib_wait_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (o_nib_start) begin
                nib_wait_q <= 1'b1;
            end else if (i_nib_done) begin
                nib_wait_q <= 1'b0;
            end
            // the index moves on as the step's delay gets loaded
            if (step_done) begin
                step_idx_q <= step_idx_q + STEP_IDX_W'(1);
            end
        end
    end

    // the host may change its inputs right after the strobe
    always_ff @(posedge CLK_I) begin
        if (accept) begin
            byte_rs_q   <= i_rs;
            byte_data_q <= i_data;
        end
    end

endmodule

//--- hw/lcd_controller.sv
`timescale 1ns/10ps

module lcd_controller (
    input  logic               CLK_I,
    input  logic               RST_I,
    input  logic               i_stb,
    input  logic               i_rs,
    input  lcd_pkg::lcd_byte_t i_data,
    output logic               o_busy,
    output logic               o_lcd_rs,
    output logic               o_lcd_e,
    output lcd_pkg::nibble_t   o_lcd_data
);
    import lcd_pkg::*;

    // sequencer to nibble writer
    logic         nib_start;
    nibble_req_t  nib_req;
    logic         nib_done;
    // sequencer to delay timer
    logic         dly_load;
    delay_ticks_t dly_ticks;
    logic         dly_expired;
    // the pins as one bundle from the writer
    lcd_bus_t     lcd_bus;

    // **************************************************
    // datapath
    // **************************************************

    // runs the init table out of reset and then takes host bytes
    lcd_step_sequencer u_sequencer (
        .CLK_I         (CLK_I),
        .RST_I         (RST_I),
        .i_stb         (i_stb),
        .i_rs          (i_rs),
        .i_data        (i_data),
        .o_busy        (o_busy),
        .o_nib_start   (nib_start),
        .o_nib_req     (nib_req),
        .i_nib_done    (nib_done),
        .o_dly_load    (dly_load),
        .o_dly_ticks   (dly_ticks),
        .i_dly_expired (dly_expired)
    );

    // one E cycle per nibble
    lcd_nibble_writer u_nibble_writer (
        .CLK_I   (CLK_I),
        .RST_I   (RST_I),
        .i_start (nib_start),
        .i_req   (nib_req),
        .o_done  (nib_done),
        .o_bus   (lcd_bus)
    );

    // the display's execution times between steps and bytes
    lcd_delay_timer u_delay_timer (
        .CLK_I     (CLK_I),
        .RST_I     (RST_I),
        .i_load    (dly_load),
        .i_ticks   (dly_ticks),
        .o_expired (dly_expired)
    );

    assign o_lcd_rs   = lcd_bus.rs;
    assign o_lcd_e    = lcd_bus.e;
    assign o_lcd_data = lcd_bus.data;

endmodule

//--- tests/lcd_controller_assertions.sv
`timescale 1ns/10ps

module lcd_controller_assertions (
    input logic             CLK_I,
    input logic             RST_I,
    input logic             i_lcd_e,
    input logic             i_lcd_rs,
    input lcd_pkg::nibble_t i_lcd_data
);
    import lcd_pkg::*;

    // number of assertion failures so far
    int fail_count;

    initial fail_count = 0;

    // **************************************************
    // E pulse shape
    // **************************************************

    // once E rises it stays high for exactly the E high width and then drops
    property p_e_width;
        @(posedge CLK_I) disable iff (RST_I)
            $rose(i_lcd_e) |-> i_lcd_e [*TICKS_PWEH] ##1 !i_lcd_e;
    endproperty

    // the display latches on the falling edge, so RS and data hold one cycle past E too
    property p_bus_stable;
        @(posedge CLK_I) disable iff (RST_I)
            i_lcd_e |=> $stable({i_lcd_rs, i_lcd_data});
    endproperty

    // E is a register, it is low one edge after reset is seen
    property p_e_low_in_reset;
        @(posedge CLK_I) RST_I |=> !i_lcd_e;
    endproperty

    assert property (p_e_width) else begin
        $error("E high time is not TICKS_PWEH cycles");
        fail_count++;
    end
    assert property (p_bus_stable) else begin
        $error("LCD data or RS changed while E was high");
        fail_count++;
    end
    assert property (p_e_low_in_reset) else begin
        $error("LCD E went high during reset");
        fail_count++;
    end

endmodule

//--- tests/lcd_controller_tb.sv
`timescale 1ns/10ps

module lcd_controller_tb;
    import lcd_pkg::*;

    // one host byte and the shortest busy time the display needs after it
    typedef struct packed {
        logic         rs;
        lcd_byte_t    data;
        delay_ticks_t min_busy;
    } host_row_t;

    localparam int NUM_ROWS = 5;
    // bound for any single wait, large enough for the whole power on sequence
    localparam int TIMEOUT_CYCLES = 2_000_000;

    logic       clk;
    logic       rst;
    logic       stb;
    logic       rs;
    lcd_byte_t  data;
    logic       busy;
    logic       lcd_rs;
    logic       lcd_e;
    nibble_t    lcd_data;
    // every nibble the display would latch, rs sits in bit 4
    logic [4:0] captured [$];
    logic [4:0] expected [$];
    host_row_t  rows [NUM_ROWS];
    int         cnt;
    int         seed;

    lcd_controller u_lcd_controller (
        .CLK_I      (clk),
        .RST_I      (rst),
        .i_stb      (stb),
        .i_rs       (rs),
        .i_data     (data),
        .o_busy     (busy),
        .o_lcd_rs   (lcd_rs),
        .o_lcd_e    (lcd_e),
        .o_lcd_data (lcd_data)
    );

    bind lcd_controller lcd_controller_assertions u_assertions (
        .CLK_I      (CLK_I),
        .RST_I      (RST_I),
        .i_lcd_e    (o_lcd_e),
        .i_lcd_rs   (o_lcd_rs),
        .i_lcd_data (o_lcd_data)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // the display takes the nibble on the falling edge of E
    always @(negedge lcd_e) begin
        if (!rst) begin
            captured.push_back({lcd_rs, lcd_data});
        end
    end

    // **************************************************
    // checker helpers
    // **************************************************

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected_val);
        if (actual !== expected_val) begin
            stop_run($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected_val));
        end
    endtask

    // counts the falling clock edges until busy drops
    task automatic wait_busy_low(input string what, output int cycles);
        cycles = 0;
        while (busy) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_run($sformatf("Timeout: o_busy never fell while waiting for %s", what));
            end
        end
    endtask

    // watch the error count of the bound pin checker
    always @(negedge clk) begin
        if (u_lcd_controller.u_assertions.fail_count != 0) begin
            stop_run("An assertion on the LCD pins failed");
        end
    end

    // **************************************************
    // stimulus
    // **************************************************

    initial begin
        seed = $urandom(32'hb73b);
        rst  = 1'b1;
        stb  = 1'b0;
        rs   = 1'b0;
        data = '0;
        rows[0] = '{1'b1, 8'h41, DELAY_CMD};
        rows[1] = '{1'b0, 8'h80, DELAY_CMD};
        rows[2] = '{1'b0, 8'h01, DELAY_CLEAR};
        rows[3] = '{1'b1, 8'h5A, DELAY_CMD};
        rows[4] = '{1'b1, lcd_byte_t'($urandom), DELAY_CMD};

        repeat (10) begin
            @(negedge clk);
            check_value("o_lcd_e in reset", lcd_e, 0);
            check_value("o_busy in reset", busy, 1);
        end
        rst = 1'b0;

        // the first cycle out of reset still shows the reset state on the pins
        @(negedge clk);
        check_value("o_lcd_e after reset", lcd_e, 0);
        check_value("o_busy after reset", busy, 1);

        // nothing may reach the display before the power on wait is over
        cnt = 1;
        while (!lcd_e) begin
            @(negedge clk);
            cnt++;
            if (cnt > TIMEOUT_CYCLES) begin
                stop_run("Timeout: the first E pulse of the init sequence never came");
            end
        end
        check_value("cycles to first E >= DELAY_POWER_ON", cnt >= DELAY_POWER_ON, 1);
        wait_busy_low("the init sequence", cnt);

        // lone reset nibbles go out as they are, full bytes upper nibble first
        for (int i = 0; i < INIT_STEPS; i++) begin
            if (INIT_TABLE[i].is_byte) begin
                expected.push_back({1'b0, INIT_TABLE[i].value[7:4]});
                expected.push_back({1'b0, INIT_TABLE[i].value[3:0]});
            end else begin
                expected.push_back({1'b0, INIT_TABLE[i].nibble});
            end
        end
        check_value("init nibble count", captured.size(), expected.size());
        while (expected.size() > 0) begin
            check_value("init {o_lcd_rs, o_lcd_data}", captured.pop_front(), expected.pop_front());
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            wait_busy_low("the previous byte", cnt);
            captured.delete();
            stb  = 1'b1;
            rs   = rows[r].rs;
            data = rows[r].data;
            @(negedge clk);
            stb = 1'b0;
            check_value("o_busy after strobe", busy, 1);
            @(negedge clk);
            // a second strobe while busy must leave no trace on the bus
            stb  = 1'b1;
            rs   = ~rows[r].rs;
            data = ~rows[r].data;
            @(negedge clk);
            stb = 1'b0;
            wait_busy_low("a host byte", cnt);
            check_value("busy cycles >= row delay", cnt >= rows[r].min_busy, 1);
            check_value("nibbles per byte", captured.size(), 2);
            check_value("upper {o_lcd_rs, o_lcd_data}", captured.pop_front(),
                        {rows[r].rs, rows[r].data[7:4]});
            check_value("lower {o_lcd_rs, o_lcd_data}", captured.pop_front(),
                        {rows[r].rs, rows[r].data[3:0]});
        end

        if (u_lcd_controller.u_assertions.fail_count != 0) begin
            stop_run("An assertion on the LCD pins failed");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

//--- files.f
hw/lcd_pkg.sv
hw/lcd_delay_timer.sv
hw/lcd_nibble_writer.sv
hw/lcd_step_sequencer.sv
hw/lcd_controller.sv
tests/lcd_controller_assertions.sv
tests/lcd_controller_tb.sv

//--- Bender.yml
package:
  name: lcd_controller

sources:
  - files:
      - hw/lcd_pkg.sv
      - hw/lcd_delay_timer.sv
      - hw/lcd_nibble_writer.sv
      - hw/lcd_step_sequencer.sv
      - hw/lcd_controller.sv
  - target: test
    files:
      - tests/lcd_controller_assertions.sv
      - tests/lcd_controller_tb.sv
